// File: bench/coreStim.txt
// gap(idle cycles) instr wen reg data, all hex, pc is implied by line order
// a gap of ffffffff ends the stream
2 24010005 1 01 00000005 // addiu r1, r0, 5
0 2402fffd 1 02 fffffffd // addiu r2, r0, -3
0 00221821 1 03 00000002 // addu r3, r1, r2
0 00222023 1 04 00000008 // subu r4, r1, r2
0 00222824 1 05 00000005 // and r5, r1, r2
0 00223025 1 06 fffffffd // or r6, r1, r2
0 00223826 1 07 fffffff8 // xor r7, r1, r2
0 00224027 1 08 00000002 // nor r8, r1, r2
0 0041482a 1 09 00000001 // slt r9, r2, r1
0 0041502b 1 0a 00000000 // sltu r10, r2, r1
0 00025900 1 0b ffffffd0 // sll r11, r2, 4
0 00026102 1 0c 0fffffff // srl r12, r2, 4
0 00026843 1 0d fffffffe // sra r13, r2, 1
0 284efffe 1 0e 00000001 // slti r14, r2, -2
0 2c2fffff 1 0f 00000001 // sltiu r15, r1, -1
0 3050ff0f 1 10 0000ff0d // andi r16, r2, 0xff0f
0 34318000 1 11 00008005 // ori r17, r1, 0x8000
0 3852ffff 1 12 ffff0002 // xori r18, r2, 0xffff
0 3c131234 1 13 12340000 // lui r19, 0x1234
0 26748001 1 14 12338001 // addiu r20, r19, -32767
0 0293a821 1 15 24678001 // addu r21, r20, r19
0 26960001 1 16 12338002 // addiu r22, r20, 1
0 26970002 1 17 12338003 // addiu r23, r20, 2
0 0017c023 1 18 edcc7ffd // subu r24, r0, r23
0 24200007 0 00 00000000 // addiu r0, r1, 7
0 0001c825 1 19 00000005 // or r25, r0, r1
0 8c250000 0 00 00000000 // lw opcode, not supported
0 00220018 0 00 00000000 // mult funct, not supported
3 241a7fff 1 1a 00007fff // addiu r26, r0, 0x7fff
5 0331d826 1 1b 00008000 // xor r27, r25, r17
ffffffff 00000000 0 00 00000000

// File: bench/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam wordT resetPc = 32'hbfc00000;
	localparam int stimDepth = 256;
	localparam int resetCycles = 5;
	localparam logic [31:0] endMarker = 32'hffffffff;
	// held on instr between strobes, an addiu to r25 if it ever leaked in
	localparam wordT idleWord = 32'h2419ffff;

	typedef struct packed {
		int index;
		int cycle;
		wordT pc;
		logic wen;
		regAddrT dest;
		wordT data;
	} expectT;

	logic clk;
	logic rstN;
	logic instrValid;
	instrT instr;
	logic debugWbValid;
	wordT debugWbPc;
	logic [3:0] debugWbRfWen;
	regAddrT debugWbRfWnum;
	wordT debugWbRfWdata;

	// five words per instruction: gap, instr, wen, reg, data
	logic [31:0] stimMem [0:stimDepth-1];
	int stimCount;
	int gapTotal;
	bit loaded;
	int cycle;
	int errorCount;
	int testsRun;
	int testsFailed;
	expectT expQ[$];

	mipsCore #(
		.resetPc(resetPc)
	) mipsCore_inst (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.debugWbValid(debugWbValid),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	always #4 clk = ~clk;

	// edge count, the value seen after an edge is that edge's number
	always @(posedge clk) begin
		if (!rstN) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkReg(input string name, input regAddrT expected, input regAddrT actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic loadStimulus();
		int i;
		$readmemh("bench/coreStim.txt", stimMem);
		stimCount = 0;
		gapTotal = 0;
		i = 0;
		while ((i + 5 <= stimDepth) && (stimMem[i] != endMarker)) begin
			gapTotal += int'(stimMem[i]);
			stimCount++;
			i += 5;
		end
		loaded = 1'b1;
	endtask

	task automatic driveStimulus();
		int gap;
		expectT entry;
		for (int n = 0; n < stimCount; n++) begin
			gap = int'(stimMem[5 * n]);
			repeat (gap) begin
				@(posedge clk);
				instrValid <= 1'b0;
				instr <= idleWord;
			end
			@(posedge clk);
			instrValid <= 1'b1;
			instr <= stimMem[5 * n + 1];
			entry.index = n;
			// this edge becomes cycle+1, the writeback shows two edges later
			entry.cycle = cycle + 3;
			entry.pc = resetPc + wordT'(4 * n);
			entry.wen = stimMem[5 * n + 2][0];
			entry.dest = stimMem[5 * n + 3][4:0];
			entry.data = stimMem[5 * n + 4];
			expQ.push_back(entry);
		end
		@(posedge clk);
		instrValid <= 1'b0;
		instr <= idleWord;
	endtask

	task automatic closeTest(input expectT entry, input bit passed);
		testsRun++;
		if (passed) begin
			$display("test %0d pc %h: passed", entry.index, entry.pc);
		end else begin
			testsFailed++;
			$display("test %0d pc %h: failed", entry.index, entry.pc);
		end
	endtask

	task automatic checkWriteback();
		expectT entry;
		int errorsBefore;
		if (debugWbValid) begin
			if (expQ.size() == 0) begin
				errorCount++;
				$display("t=%0t writeback at pc %h with no instruction outstanding",
					$time, debugWbPc);
			end else begin
				entry = expQ.pop_front();
				errorsBefore = errorCount;
				if (entry.cycle != cycle) begin
					errorCount++;
					$display("t=%0t instruction %0d wrote back at cycle %0d instead of %0d",
						$time, entry.index, cycle, entry.cycle);
				end
				checkWord("debugWbPc", entry.pc, debugWbPc);
				for (int b = 0; b < 4; b++) begin
					checkBit($sformatf("debugWbRfWen[%0d]", b), entry.wen, debugWbRfWen[b]);
				end
				if (entry.wen) begin
					checkReg("debugWbRfWnum", entry.dest, debugWbRfWnum);
					checkWord("debugWbRfWdata", entry.data, debugWbRfWdata);
				end
				closeTest(entry, errorCount == errorsBefore);
			end
		end else begin
			if (debugWbRfWen != 4'b0000) begin
				errorCount++;
				$display("t=%0t register write enable high without a valid writeback", $time);
			end
			if ((expQ.size() != 0) && (expQ[0].cycle <= cycle)) begin
				entry = expQ.pop_front();
				errorCount++;
				$display("t=%0t instruction %0d at pc %h never wrote back",
					$time, entry.index, entry.pc);
				closeTest(entry, 1'b0);
			end
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (rstN) begin
			checkWriteback();
		end
	end

	initial begin
		wait (loaded);
		wait (rstN);
		repeat (gapTotal + stimCount + 20) @(posedge clk);
		$display("watchdog expired with %0d writebacks outstanding", expQ.size());
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rstN <= 1'b0;
		instrValid <= 1'b0;
		instr <= idleWord;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		loadStimulus();
		if (stimCount == 0) begin
			errorCount++;
			$display("no instructions found in bench/coreStim.txt");
		end
		repeat (resetCycles - 1) @(posedge clk);
		@(negedge clk);
		checkBit("debugWbValid", 1'b0, debugWbValid);
		checkBit("debugWbRfWen[0]", 1'b0, debugWbRfWen[0]);
		@(posedge clk);
		rstN <= 1'b1;
		driveStimulus();
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		// a few quiet edges, any stray writeback shows up here
		repeat (4) @(posedge clk);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			testsRun, testsRun - testsFailed, testsFailed, errorCount);
		if ((errorCount == 0) && (testsRun == stimCount)) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module mipsCoreTb -o mipsCoreSim
./obj_dir/mipsCoreSim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run failed, see sim.log"
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "run ended without a result, see sim.log"
	exit 1
fi
echo "run passed"

// File: source/aluExecute.sv
`default_nettype none

module aluExecute (
	input logic exValid,
	input mipsPkg::wordT exPc,
	input mipsPkg::aluOpT exAluOp,
	input logic exUseImm,
	input logic [4:0] exShamt,
	input mipsPkg::wordT exImm,
	input mipsPkg::regAddrT exRs,
	input mipsPkg::regAddrT exRt,
	input mipsPkg::regAddrT exDest,
	input mipsPkg::wordT exRsData,
	input mipsPkg::wordT exRtData,
	input logic exWrite,
	input logic wbWrite,
	input mipsPkg::regAddrT wbDest,
	input mipsPkg::wordT wbData,
	output logic aluValid,
	output mipsPkg::wordT aluPc,
	output mipsPkg::regAddrT aluDest,
	output logic aluWrite,
	output mipsPkg::wordT aluResult
);
	import mipsPkg::*;

	wordT opA;
	wordT rtValue;
	wordT opB;
	logic lessSigned;
	logic lessUnsigned;

	// result of the previous instruction overrides stale reads
	assign opA = (wbWrite && (wbDest == exRs)) ? wbData : exRsData;
	assign rtValue = (wbWrite && (wbDest == exRt)) ? wbData : exRtData;

	assign opB = exUseImm ? exImm : rtValue;

	assign lessSigned = ($signed(opA) < $signed(opB));
	assign lessUnsigned = (opA < opB);

	always_comb begin
		case (exAluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluNor: aluResult = ~(opA | opB);
			aluSlt: aluResult = {31'd0, lessSigned};
			aluSltu: aluResult = {31'd0, lessUnsigned};
			// shifts act on rt, amount from the shamt field
			aluSll: aluResult = opB << exShamt;
			aluSrl: aluResult = opB >> exShamt;
			aluSra: aluResult = $signed(opB) >>> exShamt;
			aluLui: aluResult = {opB[15:0], 16'h0000};
			default: aluResult = '0;
		endcase
	end

	assign aluValid = exValid;
	assign aluPc = exPc;
	assign aluDest = exDest;
	assign aluWrite = exValid && exWrite;

endmodule

`default_nettype wire

// File: source/instrDecode.sv
`default_nettype none

module instrDecode #(
	parameter mipsPkg::wordT resetPc = 32'hbfc00000
) (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input mipsPkg::instrT instr,
	input mipsPkg::wordT rsData,
	input mipsPkg::wordT rtData,
	output mipsPkg::regAddrT rsAddr,
	output mipsPkg::regAddrT rtAddr,
	output logic exValid,
	output mipsPkg::wordT exPc,
	output mipsPkg::aluOpT exAluOp,
	output logic exUseImm,
	output logic [4:0] exShamt,
	output mipsPkg::wordT exImm,
	output mipsPkg::regAddrT exRs,
	output mipsPkg::regAddrT exRt,
	output mipsPkg::regAddrT exDest,
	output mipsPkg::wordT exRsData,
	output mipsPkg::wordT exRtData,
	output logic exWrite
);
	import mipsPkg::*;

	wordT pc;
	logic isSpecial;
	logic known;
	aluOpT aluOp;
	logic useImm;
	logic zeroExt;
	regAddrT dest;
	logic [4:0] shamt;
	wordT imm;

	assign isSpecial = (instr.rType.opcode == opSpecial);

	// register reads straight from the incoming word
	assign rsAddr = instr.rType.rs;
	assign rtAddr = instr.rType.rt;

	always_comb begin
		known = 1'b1;
		aluOp = aluAdd;
		useImm = 1'b0;
		zeroExt = 1'b0;
		if (isSpecial) begin
			case (instr.rType.funct)
				fnAddu: aluOp = aluAdd;
				fnSubu: aluOp = aluSub;
				fnAnd: aluOp = aluAnd;
				fnOr: aluOp = aluOr;
				fnXor: aluOp = aluXor;
				fnNor: aluOp = aluNor;
				fnSlt: aluOp = aluSlt;
				fnSltu: aluOp = aluSltu;
				fnSll: aluOp = aluSll;
				fnSrl: aluOp = aluSrl;
				fnSra: aluOp = aluSra;
				default: known = 1'b0;
			endcase
		end else begin
			useImm = 1'b1;
			case (instr.iType.opcode)
				opAddiu: aluOp = aluAdd;
				opSlti: aluOp = aluSlt;
				// sltiu still sign-extends, compare is unsigned
				opSltiu: aluOp = aluSltu;
				opAndi: begin
					aluOp = aluAnd;
					zeroExt = 1'b1;
				end
				opOri: begin
					aluOp = aluOr;
					zeroExt = 1'b1;
				end
				opXori: begin
					aluOp = aluXor;
					zeroExt = 1'b1;
				end
				opLui: begin
					aluOp = aluLui;
					zeroExt = 1'b1;
				end
				default: known = 1'b0;
			endcase
		end
	end

	// unknown encodings become a bubble to r0
	assign dest = !known ? 5'd0 : (isSpecial ? instr.rType.rd : instr.iType.rt);
	assign shamt = isSpecial ? instr.rType.shamt : 5'd0;
	assign imm = zeroExt ? {16'h0000, instr.iType.imm16}
		: {{16{instr.iType.imm16[15]}}, instr.iType.imm16};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
			exValid <= 1'b0;
			exWrite <= 1'b0;
		end else begin
			exValid <= instrValid;
			exWrite <= instrValid && known && (dest != 5'd0);
			if (instrValid) begin
				pc <= pc + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instrValid) begin
			exPc <= pc;
			exAluOp <= aluOp;
			exUseImm <= useImm;
			exShamt <= shamt;
			exImm <= imm;
			exRs <= rsAddr;
			exRt <= rtAddr;
			exDest <= dest;
			exRsData <= rsData;
			exRtData <= rtData;
		end
	end

endmodule

`default_nettype wire

// File: source/mipsCore.sv
`default_nettype none

module mipsCore #(
	parameter mipsPkg::wordT resetPc = 32'hbfc00000
) (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input mipsPkg::instrT instr,
	output logic debugWbValid,
	output mipsPkg::wordT debugWbPc,
	output logic [3:0] debugWbRfWen,
	output mipsPkg::regAddrT debugWbRfWnum,
	output mipsPkg::wordT debugWbRfWdata
);
	import mipsPkg::*;

	regAddrT rsAddr;
	regAddrT rtAddr;
	wordT rsData;
	wordT rtData;

	logic exValid;
	wordT exPc;
	aluOpT exAluOp;
	logic exUseImm;
	logic [4:0] exShamt;
	wordT exImm;
	regAddrT exRs;
	regAddrT exRt;
	regAddrT exDest;
	wordT exRsData;
	wordT exRtData;
	logic exWrite;

	logic aluValid;
	wordT aluPc;
	regAddrT aluDest;
	logic aluWrite;
	wordT aluResult;

	logic wbWrite;
	regAddrT wbDest;
	wordT wbData;

	instrDecode #(
		.resetPc(resetPc)
	) instrDecode_inst (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.exValid(exValid),
		.exPc(exPc),
		.exAluOp(exAluOp),
		.exUseImm(exUseImm),
		.exShamt(exShamt),
		.exImm(exImm),
		.exRs(exRs),
		.exRt(exRt),
		.exDest(exDest),
		.exRsData(exRsData),
		.exRtData(exRtData),
		.exWrite(exWrite)
	);

	regFile regFile_inst (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.wbWrite(wbWrite),
		.wbDest(wbDest),
		.wbData(wbData),
		.rsData(rsData),
		.rtData(rtData)
	);

	aluExecute aluExecute_inst (
		.exValid(exValid),
		.exPc(exPc),
		.exAluOp(exAluOp),
		.exUseImm(exUseImm),
		.exShamt(exShamt),
		.exImm(exImm),
		.exRs(exRs),
		.exRt(exRt),
		.exDest(exDest),
		.exRsData(exRsData),
		.exRtData(exRtData),
		.exWrite(exWrite),
		.wbWrite(wbWrite),
		.wbDest(wbDest),
		.wbData(wbData),
		.aluValid(aluValid),
		.aluPc(aluPc),
		.aluDest(aluDest),
		.aluWrite(aluWrite),
		.aluResult(aluResult)
	);

	wbResult wbResult_inst (
		.clk(clk),
		.rstN(rstN),
		.aluValid(aluValid),
		.aluPc(aluPc),
		.aluDest(aluDest),
		.aluWrite(aluWrite),
		.aluResult(aluResult),
		.wbWrite(wbWrite),
		.wbDest(wbDest),
		.wbData(wbData),
		.debugWbValid(debugWbValid),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

endmodule

`default_nettype wire

// File: source/mipsPkg.sv
`default_nettype none

package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	// same 32 bits, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			regAddrT rs;
			regAddrT rt;
			regAddrT rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0] opcode;
			regAddrT rs;
			regAddrT rt;
			logic [15:0] imm16;
		} iType;
	} instrT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,
		aluSltu,
		aluSll,
		aluSrl,
		aluSra,
		aluLui
	} aluOpT;

	// primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opSlti = 6'h0a;
	localparam logic [5:0] opSltiu = 6'h0b;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opXori = 6'h0e;
	localparam logic [5:0] opLui = 6'h0f;

	// funct field of special
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnSrl = 6'h02;
	localparam logic [5:0] fnSra = 6'h03;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnNor = 6'h27;
	localparam logic [5:0] fnSlt = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;

endpackage

`default_nettype wire

// File: source/regFile.sv
`default_nettype none

module regFile (
	input logic clk,
	input logic rstN,
	input mipsPkg::regAddrT rsAddr,
	input mipsPkg::regAddrT rtAddr,
	input logic wbWrite,
	input mipsPkg::regAddrT wbDest,
	input mipsPkg::wordT wbData,
	output mipsPkg::wordT rsData,
	output mipsPkg::wordT rtData
);
	import mipsPkg::*;

	wordT regs [32];

	// r0 reads zero, a same-cycle write is seen at once
	function automatic wordT readPort(regAddrT addr);
		wordT value;
		if (addr == 5'd0) begin
			value = '0;
		end else if (wbWrite && (wbDest == addr)) begin
			value = wbData;
		end else begin
			value = regs[addr];
		end
		return value;
	endfunction

	always_comb begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && (wbDest != 5'd0)) begin
			regs[wbDest] <= wbData;
		end
	end

endmodule

`default_nettype wire

// File: source/wbResult.sv
`default_nettype none

module wbResult (
	input logic clk,
	input logic rstN,
	input logic aluValid,
	input mipsPkg::wordT aluPc,
	input mipsPkg::regAddrT aluDest,
	input logic aluWrite,
	input mipsPkg::wordT aluResult,
	output logic wbWrite,
	output mipsPkg::regAddrT wbDest,
	output mipsPkg::wordT wbData,
	output logic debugWbValid,
	output mipsPkg::wordT debugWbPc,
	output logic [3:0] debugWbRfWen,
	output mipsPkg::regAddrT debugWbRfWnum,
	output mipsPkg::wordT debugWbRfWdata
);
	import mipsPkg::*;

	logic validQ;
	logic writeQ;
	regAddrT destQ;
	wordT pcQ;
	wordT dataQ;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
			writeQ <= 1'b0;
		end else begin
			validQ <= aluValid;
			writeQ <= aluValid && aluWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (aluValid) begin
			destQ <= aluDest;
			pcQ <= aluPc;
			dataQ <= aluResult;
		end
	end

	// register file write and forward source
	assign wbWrite = writeQ;
	assign wbDest = destQ;
	assign wbData = dataQ;

	// full word write, all byte enables together
	assign debugWbValid = validQ;
	assign debugWbPc = pcQ;
	assign debugWbRfWen = {4{writeQ}};
	assign debugWbRfWnum = destQ;
	assign debugWbRfWdata = dataQ;

endmodule

`default_nettype wire

// File: vlog.f
source/mipsPkg.sv
source/regFile.sv
source/instrDecode.sv
source/aluExecute.sv
source/wbResult.sv
source/mipsCore.sv
bench/mipsCoreTb.sv
